//--- soc_periph_cfg_pkg.sv
// APB widths, peripheral address map, slave index enum and register offsets
package soc_periph_cfg_pkg;

  typedef logic [31:0] apb_addr_t;  // byte address
  typedef logic [31:0] apb_data_t;  // read and write data
  typedef logic [7:0]  jtag_reg_t;  // jtag exchange value

  // slave pick, one 4 KiB window each
  localparam int unsigned SLAVE_IDX_LSB = 12;
  localparam int unsigned SLAVE_IDX_MSB = 13;

  typedef enum logic [1:0] {
    SEL_SOC_CTRL = 2'd0,  // 0x0000
    SEL_GPIO     = 2'd1,  // 0x1000
    SEL_TIMER    = 2'd2,  // 0x2000
    SEL_NONE     = 2'd3   // 0x3000, unmapped
  } slave_sel_e;

  // word offset inside a window
  localparam int unsigned OFF_LSB = 2;
  localparam int unsigned OFF_MSB = 11;
  typedef logic [OFF_MSB-OFF_LSB:0] reg_off_t;

  // soc control, byte offsets given, word offsets stored
  localparam reg_off_t REG_BOOTADDR   = reg_off_t'(12'h000 >> OFF_LSB);
  localparam reg_off_t REG_FETCHEN    = reg_off_t'(12'h004 >> OFF_LSB);
  localparam reg_off_t REG_JTAG       = reg_off_t'(12'h008 >> OFF_LSB);
  localparam reg_off_t REG_SOFTRST    = reg_off_t'(12'h00C >> OFF_LSB);
  localparam reg_off_t REG_BOOTSEL    = reg_off_t'(12'h010 >> OFF_LSB);
  // gpio
  localparam reg_off_t REG_GPIO_IN    = reg_off_t'(12'h000 >> OFF_LSB);
  localparam reg_off_t REG_GPIO_OUT   = reg_off_t'(12'h004 >> OFF_LSB);
  localparam reg_off_t REG_GPIO_DIR   = reg_off_t'(12'h008 >> OFF_LSB);
  localparam reg_off_t REG_GPIO_IRQEN = reg_off_t'(12'h00C >> OFF_LSB);
  localparam reg_off_t REG_GPIO_IRQST = reg_off_t'(12'h010 >> OFF_LSB);
  // timer
  localparam reg_off_t REG_TMR_CTRL   = reg_off_t'(12'h000 >> OFF_LSB);
  localparam reg_off_t REG_TMR_COUNT  = reg_off_t'(12'h004 >> OFF_LSB);
  localparam reg_off_t REG_TMR_CMP    = reg_off_t'(12'h008 >> OFF_LSB);

endpackage

//--- soc_event_pkg.sv
// fabric controller event vector type and event bit positions
package soc_event_pkg;

  localparam int unsigned FC_EVENTS_W = 32;

  typedef logic [FC_EVENTS_W-1:0] fc_events_t;

  //////////////////////////////////////////////////////////////////////
  // event map
  //////////////////////////////////////////////////////////////////////

  // 6:0 are software events, not driven here
  localparam int unsigned EVT_TIMER_MTIME = 7;   // mtime irq, same pulse as 16

  localparam int unsigned EVT_GPIO        = 11;  // level, any enabled gpio irq

  localparam int unsigned EVT_TIMER       = 16;  // timer wrap

  // ref clock edges, one clk_i cycle each
  localparam int unsigned EVT_REF_RISE    = 18;
  localparam int unsigned EVT_REF_FALL    = 19;

  // everything else tied low at the top

endpackage

//--- periph_apb_decoder.sv
// APB address decoder: per-slave select and read data, ready and error mux
`timescale 1ns/1ns

module periph_apb_decoder (
  input  soc_periph_cfg_pkg::apb_addr_t paddr_i,
  input  logic                          psel_i,
  input  soc_periph_cfg_pkg::apb_data_t soc_ctrl_prdata_i,
  input  soc_periph_cfg_pkg::apb_data_t gpio_prdata_i,
  input  soc_periph_cfg_pkg::apb_data_t timer_prdata_i,
  output logic                          soc_ctrl_psel_o,
  output logic                          gpio_psel_o,
  output logic                          timer_psel_o,
  output soc_periph_cfg_pkg::apb_data_t prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o
);

  soc_periph_cfg_pkg::slave_sel_e slave_sel;  // decoded target

  // window index from addr 13:12
  assign slave_sel = soc_periph_cfg_pkg::slave_sel_e'(
    paddr_i[soc_periph_cfg_pkg::SLAVE_IDX_MSB:soc_periph_cfg_pkg::SLAVE_IDX_LSB]);

  // no wait states anywhere, ready follows select
  assign pready_o = psel_i;

  always_comb begin
    soc_ctrl_psel_o = 1'b0;
    gpio_psel_o     = 1'b0;
    timer_psel_o    = 1'b0;
    prdata_o        = '0;    // zero for unmapped
    pslverr_o       = 1'b0;
    case (slave_sel)
      soc_periph_cfg_pkg::SEL_SOC_CTRL: begin
        soc_ctrl_psel_o = psel_i;
        prdata_o        = soc_ctrl_prdata_i;
      end
      soc_periph_cfg_pkg::SEL_GPIO: begin
        gpio_psel_o = psel_i;
        prdata_o    = gpio_prdata_i;
      end
      soc_periph_cfg_pkg::SEL_TIMER: begin
        timer_psel_o = psel_i;
        prdata_o     = timer_prdata_i;
      end
      default: begin
        // SEL_NONE, nobody selected, answer with error
        pslverr_o = psel_i;
      end
    endcase
  end

endmodule

//--- soc_ctrl_regs.sv
// soc control registers: boot address, fetch enable, jtag, bootsel, soft reset
`timescale 1ns/1ns

module soc_ctrl_regs #(
  parameter soc_periph_cfg_pkg::apb_addr_t BOOT_ADDR_DEFAULT = 32'h1C00_0800
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // apb slave, word offset only
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  soc_periph_cfg_pkg::reg_off_t  paddr_i,
  input  soc_periph_cfg_pkg::apb_data_t pwdata_i,
  output soc_periph_cfg_pkg::apb_data_t prdata_o,
  // soc side
  input  logic                          bootsel_i,
  input  soc_periph_cfg_pkg::jtag_reg_t soc_jtag_reg_i,
  output soc_periph_cfg_pkg::apb_addr_t fc_bootaddr_o,
  output logic                          fc_fetchen_o,
  output soc_periph_cfg_pkg::jtag_reg_t soc_jtag_reg_o,
  output logic                          periph_rst_n_o  // gpio and timer reset
);

  localparam int unsigned JTAG_W = $bits(soc_periph_cfg_pkg::jtag_reg_t);

  soc_periph_cfg_pkg::apb_addr_t bootaddr_q;
  soc_periph_cfg_pkg::jtag_reg_t jtag_q;
  logic                          fetchen_q;
  logic                          soft_rst_q;  // high for one cycle after write
  logic                          wr_en;

  assign wr_en = psel_i & penable_i & pwrite_i;  // access phase

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bootaddr_q <= BOOT_ADDR_DEFAULT;
      fetchen_q  <= 1'b0;
      jtag_q     <= '0;
      soft_rst_q <= 1'b0;
    end else begin
      soft_rst_q <= 1'b0;  // self clearing
      if (wr_en) begin
        case (paddr_i)
          soc_periph_cfg_pkg::REG_BOOTADDR: bootaddr_q <= pwdata_i;
          soc_periph_cfg_pkg::REG_FETCHEN:  fetchen_q  <= pwdata_i[0];
          soc_periph_cfg_pkg::REG_JTAG:     jtag_q     <= pwdata_i[JTAG_W-1:0];
          soc_periph_cfg_pkg::REG_SOFTRST:  soft_rst_q <= pwdata_i[0];
          default: ;                        // bootsel and holes are read only
        endcase
      end
    end
  end

  // read mux, holes read zero
  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      soc_periph_cfg_pkg::REG_BOOTADDR: prdata_o = bootaddr_q;
      soc_periph_cfg_pkg::REG_FETCHEN:  prdata_o[0] = fetchen_q;
      soc_periph_cfg_pkg::REG_JTAG:     prdata_o[JTAG_W-1:0] = soc_jtag_reg_i;  // input side
      soc_periph_cfg_pkg::REG_BOOTSEL:  prdata_o[0] = bootsel_i;
      default: ;                        // softrst reads zero too
    endcase
  end

  assign fc_bootaddr_o  = bootaddr_q;
  assign fc_fetchen_o   = fetchen_q;
  assign soc_jtag_reg_o = jtag_q;

  // peripherals held by chip reset or one cycle of soft reset
  assign periph_rst_n_o = arst_n_i & ~soft_rst_q;

endmodule

//--- gpio_ctrl.sv
// gpio registers, input synchronizer and rising edge interrupt status
`timescale 1ns/1ns

module gpio_ctrl #(
  parameter int unsigned NB_GPIO = 32  // at most 32
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,  // peripheral reset
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  soc_periph_cfg_pkg::reg_off_t  paddr_i,
  input  soc_periph_cfg_pkg::apb_data_t pwdata_i,
  output soc_periph_cfg_pkg::apb_data_t prdata_o,
  input  logic [NB_GPIO-1:0]            gpio_in_i,   // async pads
  output logic [NB_GPIO-1:0]            gpio_out_o,
  output logic [NB_GPIO-1:0]            gpio_dir_o,  // 1 = output
  output logic                          gpio_irq_o
);

  logic [NB_GPIO-1:0] sync_ff1, sync_ff2;  // two flop synchronizer
  logic [NB_GPIO-1:0] in_prev;             // for edge detect
  logic [NB_GPIO-1:0] in_rise;
  logic [NB_GPIO-1:0] out_q, dir_q, irqen_q, irqst_q;
  logic [NB_GPIO-1:0] st_clr;
  logic               wr_en;

  assign wr_en   = psel_i & penable_i & pwrite_i;
  assign in_rise = sync_ff2 & ~in_prev;

  // write 1 to clear
  assign st_clr = (wr_en && paddr_i == soc_periph_cfg_pkg::REG_GPIO_IRQST) ?
                  pwdata_i[NB_GPIO-1:0] : '0;

  //////////////////////////////////////////////////////////////////////
  // input path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_ff1 <= '0;
      sync_ff2 <= '0;
      in_prev  <= '0;
      irqst_q  <= '0;
    end else begin
      sync_ff1 <= gpio_in_i;
      sync_ff2 <= sync_ff1;
      in_prev  <= sync_ff2;
      irqst_q  <= (irqst_q & ~st_clr) | in_rise;  // edge beats clear
    end
  end

  // control registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q   <= '0;
      dir_q   <= '0;
      irqen_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        soc_periph_cfg_pkg::REG_GPIO_OUT:   out_q   <= pwdata_i[NB_GPIO-1:0];
        soc_periph_cfg_pkg::REG_GPIO_DIR:   dir_q   <= pwdata_i[NB_GPIO-1:0];
        soc_periph_cfg_pkg::REG_GPIO_IRQEN: irqen_q <= pwdata_i[NB_GPIO-1:0];
        default: ;  // in is read only, status handled above
      endcase
    end
  end

  always_comb begin
    prdata_o = '0;  // upper bits zero when NB_GPIO < 32
    case (paddr_i)
      soc_periph_cfg_pkg::REG_GPIO_IN:    prdata_o[NB_GPIO-1:0] = sync_ff2;
      soc_periph_cfg_pkg::REG_GPIO_OUT:   prdata_o[NB_GPIO-1:0] = out_q;
      soc_periph_cfg_pkg::REG_GPIO_DIR:   prdata_o[NB_GPIO-1:0] = dir_q;
      soc_periph_cfg_pkg::REG_GPIO_IRQEN: prdata_o[NB_GPIO-1:0] = irqen_q;
      soc_periph_cfg_pkg::REG_GPIO_IRQST: prdata_o[NB_GPIO-1:0] = irqst_q;
      default: ;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign gpio_irq_o = |(irqst_q & irqen_q);  // level while any enabled bit set

endmodule

//--- ref_clk_edge_sync.sv
// reference clock synchronizer with rise and fall pulse outputs
`timescale 1ns/1ns

module ref_clk_edge_sync (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic ref_clk_i,  // slow, async to clk_i
  output logic rise_o,     // one clk_i cycle per edge
  output logic fall_o
);

  logic sync_ff1;
  logic sync_ff2;
  logic prev_ff;   // third flop, last seen level

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_ff1 <= 1'b0;
      sync_ff2 <= 1'b0;
      prev_ff  <= 1'b0;
    end else begin
      sync_ff1 <= ref_clk_i;
      sync_ff2 <= sync_ff1;
      prev_ff  <= sync_ff2;
    end
  end

  // edge = last two flops disagree
  assign rise_o = sync_ff2 & ~prev_ff;
  assign fall_o = ~sync_ff2 & prev_ff;

endmodule

//--- timer_unit.sv
// reference tick timer with compare, enable, stop input and wrap interrupt
`timescale 1ns/1ns

module timer_unit (
  input  logic                          clk_i,
  input  logic                          arst_n_i,  // peripheral reset
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  soc_periph_cfg_pkg::reg_off_t  paddr_i,
  input  soc_periph_cfg_pkg::apb_data_t pwdata_i,
  output soc_periph_cfg_pkg::apb_data_t prdata_o,
  input  logic                          tick_i,      // ref clock rise
  input  logic                          stoptimer_i, // debug halt
  output logic                          irq_o        // one cycle on wrap
);

  soc_periph_cfg_pkg::apb_data_t count_q;
  soc_periph_cfg_pkg::apb_data_t cmp_q;
  logic                          en_q;
  logic                          irq_q;
  logic                          wr_en;
  logic                          advance;

  assign wr_en   = psel_i & penable_i & pwrite_i;
  assign advance = tick_i & en_q & ~stoptimer_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
      cmp_q   <= '1;    // all ones, wraps late
      en_q    <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      irq_q <= 1'b0;
      if (wr_en && paddr_i == soc_periph_cfg_pkg::REG_TMR_CTRL) en_q <= pwdata_i[0];
      if (wr_en && paddr_i == soc_periph_cfg_pkg::REG_TMR_CMP) cmp_q <= pwdata_i;
      // bus write to count wins over a tick
      if (wr_en && paddr_i == soc_periph_cfg_pkg::REG_TMR_COUNT) begin
        count_q <= pwdata_i;
      end else if (advance) begin
        if (count_q == cmp_q) begin
          count_q <= '0;  // wrap at compare
          irq_q   <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      soc_periph_cfg_pkg::REG_TMR_CTRL:  prdata_o[0] = en_q;
      soc_periph_cfg_pkg::REG_TMR_COUNT: prdata_o = count_q;
      soc_periph_cfg_pkg::REG_TMR_CMP:   prdata_o = cmp_q;
      default: ;
    endcase
  end

  assign irq_o = irq_q;

endmodule

//--- soc_periph_top.sv
// soc peripheral block top: decoder, peripherals and fc event map
`timescale 1ns/1ns

module soc_periph_top #(
  parameter int unsigned                   NB_GPIO           = 32,
  parameter soc_periph_cfg_pkg::apb_addr_t BOOT_ADDR_DEFAULT = 32'h1C00_0800
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          ref_clk_i,
  input  logic                          stoptimer_i,
  input  logic                          bootsel_i,
  input  soc_periph_cfg_pkg::jtag_reg_t soc_jtag_reg_i,
  // apb slave port
  input  soc_periph_cfg_pkg::apb_addr_t paddr_i,
  input  soc_periph_cfg_pkg::apb_data_t pwdata_i,
  input  logic                          pwrite_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  output soc_periph_cfg_pkg::apb_data_t prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  // soc control
  output soc_periph_cfg_pkg::apb_addr_t fc_bootaddr_o,
  output logic                          fc_fetchen_o,
  output soc_periph_cfg_pkg::jtag_reg_t soc_jtag_reg_o,
  // gpio pads
  input  logic [NB_GPIO-1:0]            apbio_in_i,
  output logic [NB_GPIO-1:0]            apbio_out_o,
  output logic [NB_GPIO-1:0]            apbio_oe_o,
  output soc_event_pkg::fc_events_t     fc_events_o
);

  soc_periph_cfg_pkg::reg_off_t  reg_off;  // shared word offset
  soc_periph_cfg_pkg::apb_data_t soc_ctrl_prdata, gpio_prdata, timer_prdata;
  logic soc_ctrl_psel, gpio_psel, timer_psel;
  logic periph_rst_n;                      // chip or soft reset
  logic ref_rise, ref_fall;
  logic timer_irq, gpio_irq;

  assign reg_off = paddr_i[soc_periph_cfg_pkg::OFF_MSB:soc_periph_cfg_pkg::OFF_LSB];

  //////////////////////////////////////////////////////////////////////
  // bus
  //////////////////////////////////////////////////////////////////////

  periph_apb_decoder i_periph_apb_decoder (
    .paddr_i          (paddr_i),
    .psel_i           (psel_i),
    .soc_ctrl_prdata_i(soc_ctrl_prdata),
    .gpio_prdata_i    (gpio_prdata),
    .timer_prdata_i   (timer_prdata),
    .soc_ctrl_psel_o  (soc_ctrl_psel),
    .gpio_psel_o      (gpio_psel),
    .timer_psel_o     (timer_psel),
    .prdata_o         (prdata_o),
    .pready_o         (pready_o),
    .pslverr_o        (pslverr_o)
  );

  //////////////////////////////////////////////////////////////////////
  // peripherals
  //////////////////////////////////////////////////////////////////////

  soc_ctrl_regs #(
    .BOOT_ADDR_DEFAULT(BOOT_ADDR_DEFAULT)
  ) i_soc_ctrl_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),  // survives soft reset
    .psel_i        (soc_ctrl_psel),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (reg_off),
    .pwdata_i      (pwdata_i),
    .prdata_o      (soc_ctrl_prdata),
    .bootsel_i     (bootsel_i),
    .soc_jtag_reg_i(soc_jtag_reg_i),
    .fc_bootaddr_o (fc_bootaddr_o),
    .fc_fetchen_o  (fc_fetchen_o),
    .soc_jtag_reg_o(soc_jtag_reg_o),
    .periph_rst_n_o(periph_rst_n)
  );

  gpio_ctrl #(
    .NB_GPIO(NB_GPIO)
  ) i_gpio_ctrl (
    .clk_i     (clk_i),
    .arst_n_i  (periph_rst_n),
    .psel_i    (gpio_psel),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (reg_off),
    .pwdata_i  (pwdata_i),
    .prdata_o  (gpio_prdata),
    .gpio_in_i (apbio_in_i),
    .gpio_out_o(apbio_out_o),
    .gpio_dir_o(apbio_oe_o),
    .gpio_irq_o(gpio_irq)
  );

  ref_clk_edge_sync i_ref_clk_edge_sync (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ref_clk_i(ref_clk_i),
    .rise_o   (ref_rise),
    .fall_o   (ref_fall)
  );

  timer_unit i_timer_unit (
    .clk_i      (clk_i),
    .arst_n_i   (periph_rst_n),
    .psel_i     (timer_psel),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (reg_off),
    .pwdata_i   (pwdata_i),
    .prdata_o   (timer_prdata),
    .tick_i     (ref_rise),  // one count per ref rise
    .stoptimer_i(stoptimer_i),
    .irq_o      (timer_irq)
  );

  // fc event map, unused lines low
  always_comb begin
    fc_events_o                                 = '0;
    fc_events_o[soc_event_pkg::EVT_TIMER_MTIME] = timer_irq;
    fc_events_o[soc_event_pkg::EVT_GPIO]        = gpio_irq;
    fc_events_o[soc_event_pkg::EVT_TIMER]       = timer_irq;
    fc_events_o[soc_event_pkg::EVT_REF_RISE]    = ref_rise;
    fc_events_o[soc_event_pkg::EVT_REF_FALL]    = ref_fall;
  end

endmodule

//--- tb_soc_periph.sv
// soc peripheral block testbench with clocks, apb tasks and directed and random checks
`timescale 1ns/1ns

module tb_soc_periph;

  // dut inputs start at known values
  logic        clk_i = 1'b0, ref_clk_i = 1'b0, arst_n_i = 1'b0;
  logic        stoptimer_i = 1'b0, bootsel_i = 1'b0;
  logic        psel_i = 1'b0, penable_i = 1'b0, pwrite_i = 1'b0;
  logic [31:0] paddr_i = '0, pwdata_i = '0, apbio_in_i = '0;
  logic [7:0]  soc_jtag_reg_i = '0, soc_jtag_reg_o;
  logic [31:0] prdata_o, fc_bootaddr_o, apbio_out_o, apbio_oe_o, fc_events_o;
  logic        pready_o, pslverr_o, fc_fetchen_o;

  logic [31:0] rng_state = 32'd76239;  // xorshift state
  int          err_cnt = 0, test_err_base = 0, tests_ok = 0, tests_bad = 0;

  soc_periph_top i_soc_periph_top (.*);

  always #50 clk_i = ~clk_i;           // 100 ns
  always #400 ref_clk_i = ~ref_clk_i;  // ref period of 8 clk cycles

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("Fail at %0t ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // apb master
  //////////////////////////////////////////////////////////////////////

  // setup then access with the response sampled inside the access cycle
  task automatic apb_access(input logic [31:0] addr, input logic wr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk_i);
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    #10;
    rdata = prdata_o;
    expect_true(pready_o, "pready low in access cycle");
    expect_true(pslverr_o == (addr[13:12] == 2'd3), "pslverr does not match window");
    @(negedge clk_i);  // write has landed by now
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    apb_access(addr, 1'b1, wdata, unused_rd);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata);
    apb_access(addr, 1'b0, '0, rdata);
  endtask

  // bounded wait for one fc event bit
  task automatic wait_event(input int idx, input int max_cycles);
    int n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!fc_events_o[idx[4:0]] && n < max_cycles);
    if (!fc_events_o[idx[4:0]]) begin
      $display("timeout: fc event bit %0d not seen within %0d cycles", idx, max_cycles);
      err_cnt++;
    end
  endtask

  initial begin
    logic [31:0] rd, val, boot;
    logic [4:0]  pin;
    int unsigned ncmp, ticks, n;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    // soc control
    expect_true(fc_bootaddr_o == 32'h1C00_0800, "boot address reset value");
    expect_true(!fc_fetchen_o && apbio_oe_o == 0 && fc_events_o == 0, "outputs not reset");
    boot = next_random();
    apb_write(32'h0000, boot);
    apb_read(32'h0000, rd);
    expect_true(fc_bootaddr_o == boot && rd == boot, "boot address write");
    apb_write(32'h0004, 32'h1);
    expect_true(fc_fetchen_o, "fetch enable not set");
    val = next_random();
    apb_write(32'h0008, val);
    expect_true(soc_jtag_reg_o == val[7:0], "jtag output");
    soc_jtag_reg_i = val[15:8];           // read side shows the input
    apb_read(32'h0008, rd);
    expect_true(rd == {24'h0, val[15:8]}, "jtag read");
    bootsel_i = 1'b1;
    apb_read(32'h0010, rd);
    expect_true(rd == 32'h1, "bootsel read");
    end_test("soc control");
    // decoder with unmapped window 3
    for (int i = 0; i < 4; i++) begin
      apb_read(32'h3000 | (next_random() & 32'h0FFC), rd);
      expect_true(rd == 0, "unmapped read data not zero");
    end
    apb_write(32'h3008, next_random());   // same offset as timer compare
    apb_read(32'h2008, rd);
    expect_true(rd == 32'hFFFF_FFFF, "timer compare reset value");
    end_test("decoder");
    // gpio data path
    val = next_random();
    apb_write(32'h1004, val);
    expect_true(apbio_out_o == val, "gpio out");
    val = next_random();
    apb_write(32'h1008, val);
    expect_true(apbio_oe_o == val, "gpio dir");
    val = next_random();
    apbio_in_i = val;
    repeat (2) @(negedge clk_i);          // synchronizer depth
    apb_read(32'h1000, rd);
    expect_true(rd == val, "gpio in");
    end_test("gpio data");
    // gpio irq on one random pin
    pin = 5'(next_random());
    apbio_in_i[pin] = 1'b0;
    repeat (3) @(negedge clk_i);
    apb_write(32'h1010, 32'hFFFF_FFFF);   // drop old status
    apbio_in_i[pin] = 1'b1;
    repeat (3) @(negedge clk_i);          // sync, edge, status
    apb_read(32'h1010, rd);
    expect_true(rd == (32'h1 << pin), "status bit not set by rising edge");
    expect_true(!fc_events_o[11], "gpio event while disabled");
    apb_write(32'h100C, 32'h1 << pin);
    expect_true(fc_events_o[11], "gpio event not raised by enable");
    apb_write(32'h1010, 32'h1 << pin);
    apb_read(32'h1010, rd);
    expect_true(rd == 0 && !fc_events_o[11], "status clear");
    end_test("gpio irq");
    // ref edges
    wait_event(18, 20);
    @(negedge clk_i);
    expect_true(!fc_events_o[18], "ref rise pulse longer than one cycle");
    wait_event(19, 8);
    @(negedge clk_i);
    expect_true(!fc_events_o[19], "ref fall pulse longer than one cycle");
    // timer wrap after ncmp+1 ticks
    ncmp = 2 + (next_random() % 4);
    apb_write(32'h2008, ncmp);
    apb_write(32'h2004, 32'h0);
    apb_write(32'h2000, 32'h1);
    wait_event(16, (ncmp + 2) * 8 + 8);
    ticks = 0;
    n = 0;
    while (n < (ncmp + 2) * 8 + 8) begin
      @(negedge clk_i);
      n++;
      expect_true(fc_events_o[7] == fc_events_o[16], "timer event bits 7 and 16 differ");
      if (fc_events_o[16]) break;
      if (fc_events_o[18]) ticks++;
    end
    expect_true(fc_events_o[16] && ticks == ncmp + 1, "timer wrap not after N+1 ticks");
    apb_read(32'h2004, rd);
    expect_true(rd <= ncmp, "count above compare");
    stoptimer_i = 1'b1;
    apb_write(32'h2004, 32'd100);         // above any compare so no wrap
    repeat (3) wait_event(18, 12);
    apb_read(32'h2004, rd);
    expect_true(rd == 32'd100, "count moved while stopped");
    stoptimer_i = 1'b0;
    end_test("ref edges and timer");
    // soft reset hits gpio and timer only
    apb_write(32'h1004, next_random() | 32'h1);
    apb_write(32'h1008, next_random() | 32'h1);
    apb_write(32'h2004, 32'd100);
    apb_write(32'h000C, 32'h1);
    expect_true(apbio_out_o == 0 && apbio_oe_o == 0, "gpio pins kept after soft reset");
    apb_read(32'h1004, rd);
    expect_true(rd == 0, "gpio out after soft reset");
    apb_read(32'h1008, rd);
    expect_true(rd == 0, "gpio dir after soft reset");
    apb_read(32'h2004, rd);
    expect_true(rd == 0, "timer count after soft reset");
    apb_read(32'h2000, rd);
    expect_true(rd == 0, "timer enable after soft reset");
    expect_true(fc_bootaddr_o == boot && fc_fetchen_o, "soc control lost by soft reset");
    end_test("soft reset");
    $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
soc_periph_cfg_pkg.sv
soc_event_pkg.sv
periph_apb_decoder.sv
soc_ctrl_regs.sv
gpio_ctrl.sv
ref_clk_edge_sync.sv
timer_unit.sv
soc_periph_top.sv
tb_soc_periph.sv

//--- run.sh
#!/bin/sh
# compile and run the soc peripheral testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_soc_periph -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
